// File: Makefile
# Verilator build and run of the PET bus core testbench

VERILATOR ?= verilator
TOP       ?= pet_bus_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(BUILD_DIR)

// File: flist.f
verilog/pet_bus_pkg.sv
verilog/spi_target.sv
verilog/bus_sequencer.sv
verilog/address_decode.sv
verilog/control_reg.sv
verilog/pet_bus_top.sv
verif/tb_clk_gen.sv
verif/pet_bus_tb.sv

// File: verif/pet_bus_tb.sv
/* Testbench for the PET bus core: SPI master, bus memory model and checking assertions
   Runs the six behaviors in order and prints one line per test plus a summary */
`timescale 1ns/1ps

module pet_bus_tb;
    logic clk, rst_n;
    logic sck, cs_n, mosi, miso, spi_ready;
    logic [15:0] stim_addr;                 // Address the 6502 would drive
    pet_bus_pkg::cpu_addr_t bus_addr_i;
    pet_bus_pkg::data_t     bus_data_i, bus_data_o;
    pet_bus_pkg::addr_t     bus_addr_o;
    logic bus_addr_oe, bus_data_oe, bus_rw_ni, bus_rw_no, bus_rw_noe, gfx;
    logic cpu_clk, cpu_res, cpu_ready, cpu_be;
    logic ram_oe, ram_we, pia1_cs, pia2_cs, via_cs, io_oe;
    logic [1:0] ram_addr;

    logic reset_chk, wr_chk, ctrl_chk;       // Enable the per-test assertions
    pet_bus_pkg::addr_t exp_addr;
    pet_bus_pkg::data_t exp_data;
    int err_cnt, tests_run, tests_failed, test_err0;
    int we_seen, cs_hits;

    tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    pet_bus_top uut (
        .clk16_i(clk), .rst_n_i(rst_n),
        .spi1_sck_i(sck), .spi1_cs_ni(cs_n), .spi1_rx_i(mosi),
        .spi1_tx_o(miso), .spi_ready_o(spi_ready),
        .bus_addr_i(bus_addr_i), .bus_addr_o(bus_addr_o), .bus_addr_oe_o(bus_addr_oe),
        .bus_data_i(bus_data_i), .bus_data_o(bus_data_o), .bus_data_oe_o(bus_data_oe),
        .bus_rw_ni(bus_rw_ni), .bus_rw_no(bus_rw_no), .bus_rw_noe_o(bus_rw_noe),
        .cpu_clk_o(cpu_clk), .cpu_res_o(cpu_res), .cpu_ready_o(cpu_ready), .cpu_be_o(cpu_be),
        .ram_oe_o(ram_oe), .ram_we_o(ram_we), .ram_addr_o(ram_addr),
        .pia1_cs_o(pia1_cs), .pia2_cs_o(pia2_cs), .via_cs_o(via_cs), .io_oe_o(io_oe),
        .gfx_i(gfx)
    );

    // Bus model, FPGA address wins while it drives the bus
    assign bus_addr_i = bus_addr_oe ? bus_addr_o[15:0] : stim_addr;
    assign bus_data_i = bus_addr_i[7:0] ^ 8'h5A;

    function automatic void report_value(string name, logic [31:0] got, logic [31:0] exp);
        $display("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, exp);
        err_cnt++;
    endfunction

    function automatic void report_error(string msg);
        $display("Error: %s", msg);
        err_cnt++;
    endfunction

    always @(posedge clk) begin
        if (ram_we) we_seen <= we_seen + 1;
        if (pia1_cs || pia2_cs || via_cs) cs_hits <= cs_hits + 1;
    end

    // Idle outputs right after reset
    a_rst_res: assert property (@(posedge clk) disable iff (!rst_n)
        reset_chk |-> cpu_res && !cpu_ready && spi_ready)
        else report_error("CPU control or spi_ready not at reset value");
    a_rst_oe: assert property (@(posedge clk) disable iff (!rst_n)
        reset_chk |-> !(bus_addr_oe | bus_data_oe | bus_rw_noe | ram_oe | io_oe))
        else report_error("an output enable is high after reset");
    a_rst_cs: assert property (@(posedge clk) disable iff (!rst_n)
        reset_chk |-> !(pia1_cs | pia2_cs | via_cs | ram_we))
        else report_error("a chip select or ram_we_o is high after reset");

    // SPI write puts the sent address and data on the bus
    a_wr_addr: assert property (@(posedge clk) disable iff (!rst_n)
        wr_chk && bus_data_oe |-> bus_addr_o == exp_addr)
        else report_value("bus_addr_o", 32'(bus_addr_o), 32'(exp_addr));
    a_wr_data: assert property (@(posedge clk) disable iff (!rst_n)
        wr_chk && bus_data_oe |-> bus_data_o == exp_data)
        else report_value("bus_data_o", 32'(bus_data_o), 32'(exp_data));
    a_wr_rw: assert property (@(posedge clk) disable iff (!rst_n)
        wr_chk && bus_addr_oe |-> !bus_rw_no)
        else report_value("bus_rw_no", 32'(bus_rw_no), 32'h0);
    a_rw_oe: assert property (@(posedge clk) disable iff (!rst_n)
        bus_addr_oe |-> bus_rw_noe)
        else report_error("bus_rw_noe_o low while the FPGA drives the address");
    a_we_slot: assert property (@(posedge clk) disable iff (!rst_n)
        ram_we |-> bus_data_oe)
        else report_error("ram_we_o high outside an SPI write slot");
    a_be: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_be != bus_addr_oe)
        else report_value("cpu_be_o", 32'(cpu_be), 32'(!bus_addr_oe));
    a_ctrl_we: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_chk |-> !ram_we)
        else report_error("ram_we_o pulsed on a control register write");

    // A11:A10 pass straight through to the RAM
    a_ram_addr: assert property (@(posedge clk) disable iff (!rst_n)
        !bus_addr_oe |-> ram_addr == stim_addr[11:10])
        else report_value("ram_addr_o", 32'(ram_addr), 32'(stim_addr[11:10]));

    // CPU slot chip selects follow the PET map
    a_pia1: assert property (@(posedge clk) disable iff (!rst_n)
        pia1_cs |-> bus_addr_i[15:4] == 12'hE81 && cpu_clk && !bus_addr_oe)
        else report_value("pia1_cs_o addr", 32'(bus_addr_i), 32'hE810);
    a_pia2: assert property (@(posedge clk) disable iff (!rst_n)
        pia2_cs |-> bus_addr_i[15:4] == 12'hE82 && cpu_clk && !bus_addr_oe)
        else report_value("pia2_cs_o addr", 32'(bus_addr_i), 32'hE820);
    a_via: assert property (@(posedge clk) disable iff (!rst_n)
        via_cs |-> bus_addr_i[15:4] == 12'hE84 && cpu_clk && !bus_addr_oe)
        else report_value("via_cs_o addr", 32'(bus_addr_i), 32'hE840);
    a_io: assert property (@(posedge clk) disable iff (!rst_n)
        io_oe |-> bus_addr_i[15:8] == 8'hE8 && cpu_clk && !bus_addr_oe)
        else report_value("io_oe_o addr", 32'(bus_addr_i), 32'hE800);

    task automatic next_cycle();
        @(posedge clk);
        #10;                                // Drive just after the edge
    endtask

    // One mode 0 byte, SCK half period of 8 clocks
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            mosi = tx[i];
            repeat (8) next_cycle();
            sck   = 1'b1;
            rx[i] = miso;
            repeat (8) next_cycle();
            sck = 1'b0;
        end
    endtask

    task automatic spi_command(input logic rw_n, input pet_bus_pkg::addr_t addr,
                               input pet_bus_pkg::data_t data, output logic [7:0] miso0);
        logic [7:0] unused;
        cs_n = 1'b0;
        repeat (8) next_cycle();
        spi_byte({rw_n, 6'd0, addr[16]}, miso0);
        spi_byte(addr[15:8], unused);
        spi_byte(addr[7:0], unused);
        spi_byte(data, unused);
        repeat (8) next_cycle();
        cs_n = 1'b1;
        repeat (4) next_cycle();            // Let CS rise pass the synchronizer
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (!spi_ready && n < limit) begin
            next_cycle();
            n++;
        end
        if (!spi_ready) report_error("spi_ready_o did not return in time");
    endtask

    task automatic begin_test();
        test_err0 = err_cnt;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_err0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, err_cnt - test_err0);
            tests_failed++;
        end
    endtask

    initial begin
        logic [7:0] rx;
        logic [31:0] r;
        pet_bus_pkg::addr_t a;
        pet_bus_pkg::data_t d;
        int n, we0;
        sck          = 1'b0;
        cs_n         = 1'b1;
        mosi         = 1'b0;
        stim_addr    = 16'hFFFF;
        bus_rw_ni    = 1'b1;
        gfx          = 1'b0;
        reset_chk    = 1'b0;
        wr_chk       = 1'b0;
        ctrl_chk     = 1'b0;
        exp_addr     = '0;
        exp_data     = '0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        we_seen      = 0;
        cs_hits      = 0;
        r = $urandom(32'h12f1fb75);         // Seed once
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (!rst_n && n < 100);
        if (!rst_n) report_error("reset was never released");

        begin_test();
        reset_chk = 1;
        repeat (20) next_cycle();
        reset_chk = 0;
        end_test("reset state");

        begin_test();
        wr_chk = 1;
        we0 = we_seen;
        for (int i = 0; i < 3; i++) begin
            r = $urandom % 32'h9000;
            exp_addr = {1'b0, r[15:0]};
            r = $urandom;
            exp_data = r[7:0];
            spi_command(1'b0, exp_addr, exp_data, rx);
            wait_ready(40);
        end
        wr_chk = 0;
        a_we_seen: assert (we_seen > we0) else report_error("no ram_we_o pulse on RAM writes");
        end_test("spi ram write");

        begin_test();
        r = $urandom % 32'h9000;
        a = {1'b0, r[15:0]};
        spi_command(1'b1, a, 8'h00, rx);
        wait_ready(40);
        gfx = 1;
        spi_command(1'b1, pet_bus_pkg::GFX_ADDR, 8'h00, rx);
        a_rd_ram: assert (rx == (a[7:0] ^ 8'h5A))
            else report_value("miso byte0", 32'(rx), 32'(a[7:0] ^ 8'h5A));
        wait_ready(40);
        gfx = 0;
        spi_command(1'b1, pet_bus_pkg::GFX_ADDR, 8'h00, rx);
        a_rd_gfx1: assert (rx == 8'h01) else report_value("miso byte0", 32'(rx), 32'h01);
        wait_ready(40);
        spi_command(1'b1, a, 8'h00, rx);
        a_rd_gfx0: assert (rx == 8'h00) else report_value("miso byte0", 32'(rx), 32'h00);
        wait_ready(40);
        end_test("spi read");

        begin_test();
        ctrl_chk = 1;
        r = $urandom;
        d = r[7:0];
        for (int i = 0; i < 2; i++) begin
            spi_command(1'b0, pet_bus_pkg::CTRL_REG_ADDR, d, rx);
            wait_ready(40);
            a_res: assert (cpu_res == d[0])
                else report_value("cpu_res_o", 32'(cpu_res), 32'(d[0]));
            a_rdy: assert (cpu_ready == d[1])
                else report_value("cpu_ready_o", 32'(cpu_ready), 32'(d[1]));
            d = d ^ 8'h03;                  // Flip both lines
        end
        ctrl_chk = 0;
        end_test("control register");

        begin_test();
        for (int i = 0; i < 48; i++) begin
            r = $urandom;
            stim_addr = (i % 2 == 1) ? {8'hE8, r[7:0]} : r[15:0];
            repeat (16) next_cycle();
        end
        stim_addr = 16'hFFFF;
        a_cs_seen: assert (cs_hits > 0) else report_error("no PIA or VIA select was reached");
        end_test("cpu slot decode");

        begin_test();
        we0 = we_seen;
        spi_command(1'b0, 17'h00123, 8'hA5, rx);
        spi_command(1'b0, 17'h00456, 8'h3C, rx);
        wait_ready(40);
        a_bp_we: assert (we_seen > we0) else report_error("first back-to-back write never completed");
        end_test("back-pressure");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verif/tb_clk_gen.sv
/* Testbench clock and reset source, 100 ns period
   Reset held low for 8 cycles, released just after a rising edge */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;             // Synchronous reset, seen on 8 edges
        repeat (8) @(posedge clk_o);
        #10;
        rst_n_o = 1'b1;
    end

endmodule

// File: verilog/address_decode.sv
/* PET memory-map decoder, 17-bit bus address to region enables
   Purely combinational; FPGA register space selects nothing */
`timescale 1ns/1ps

module address_decode (
    input  pet_bus_pkg::addr_t   addr_i,
    output pet_bus_pkg::region_t region_o
);
    pet_bus_pkg::cpu_addr_t cpu_addr;
    logic                   pet_space;      // Bit 16 clear

    assign cpu_addr  = addr_i[15:0];
    assign pet_space = ~addr_i[16];

    always_comb begin
        region_o = '0;
        if (pet_space) begin
            region_o.ram  = cpu_addr < pet_bus_pkg::RAM_TOP;
            // Whole E8xx page
            region_o.io   = cpu_addr[15:8] == pet_bus_pkg::IO_BASE[15:8];
            // 16-byte windows inside the I/O page
            region_o.pia1 = cpu_addr[15:4] == pet_bus_pkg::PIA1_BASE[15:4];
            region_o.pia2 = cpu_addr[15:4] == pet_bus_pkg::PIA2_BASE[15:4];
            region_o.via  = cpu_addr[15:4] == pet_bus_pkg::VIA_BASE[15:4];
        end
    end

endmodule

// File: verilog/bus_sequencer.sv
/* 16-phase bus cycle: SPI slot in phases 4-7, CPU slot and 6502 clock in the second half
   Grants one pending SPI transaction per cycle and pulses done at the end of its slot */
`timescale 1ns/1ps

module bus_sequencer (
    input  logic clk16_i,
    input  logic rst_n_i,
    input  logic txn_valid_i,
    output logic txn_done_o,
    output logic spi_en_o,
    output logic cpu_en_o,
    output logic strobe_o,
    output logic cpu_clk_o,
    output logic cpu_be_o
);
    typedef enum logic [1:0] {
        IDLE,       // Nothing pending
        GRANTED,    // Request seen, waiting for the slot
        ACTIVE      // FPGA owns the bus
    } state_e;

    state_e                 state_q;
    pet_bus_pkg::phase_t    phase_q;
    logic                   accept;

    // Free-running, 0 on the first cycle out of reset
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) phase_q <= '0;
        else          phase_q <= phase_q + 4'd1;   // Wraps 15 -> 0
    end

    // Slot decision made one phase ahead of the SPI slot
    assign accept = phase_q == pet_bus_pkg::phase_t'(pet_bus_pkg::PH_SPI_FIRST - 4'd1);

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (txn_valid_i) state_q <= GRANTED;
                GRANTED: if (accept)      state_q <= ACTIVE;
                ACTIVE:  if (txn_done_o)  state_q <= IDLE;
                default:                  state_q <= IDLE;
            endcase
        end
    end

    assign spi_en_o   = state_q == ACTIVE;   // Phases 4..7 only
    assign txn_done_o = spi_en_o && phase_q == pet_bus_pkg::PH_SPI_LAST;
    assign cpu_en_o   = phase_q >= pet_bus_pkg::PH_CPU_FIRST &&
                        phase_q <= pet_bus_pkg::PH_CPU_LAST;
    assign cpu_clk_o  = phase_q >= pet_bus_pkg::PH_CPU_CLK_RISE;
    assign strobe_o   = phase_q == pet_bus_pkg::PH_STROBE_A ||
                        phase_q == pet_bus_pkg::PH_STROBE_A + 4'd1 ||
                        phase_q == pet_bus_pkg::PH_STROBE_B ||
                        phase_q == pet_bus_pkg::PH_STROBE_B + 4'd1;
    assign cpu_be_o   = ~spi_en_o;           // 6502 off the bus during SPI slot

    a_slots_disjoint: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        !(spi_en_o && cpu_en_o));

    // Done only after a full slot that followed a grant
    a_done_after_grant: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        txn_done_o |-> state_q == ACTIVE && $past(state_q, 4) == GRANTED);

endmodule

// File: verilog/control_reg.sv
/* FPGA control register written over SPI
   Bit 0 drives the 6502 reset, bit 1 its ready line */
`timescale 1ns/1ps

module control_reg (
    input  logic               clk16_i,
    input  logic               rst_n_i,
    input  logic               wr_en_i,
    input  pet_bus_pkg::addr_t addr_i,
    input  pet_bus_pkg::data_t data_i,
    output logic               cpu_res_o,
    output logic               cpu_ready_o
);
    logic sel;

    assign sel = wr_en_i && addr_i == pet_bus_pkg::CTRL_REG_ADDR;

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            cpu_res_o   <= 1'b1;        // CPU held in reset until the MCU releases it
            cpu_ready_o <= 1'b0;
        end else if (sel) begin
            cpu_res_o   <= data_i[0];
            cpu_ready_o <= data_i[1];
        end
    end

endmodule

// File: verilog/pet_bus_pkg.sv
/* Bus widths, PET memory map, sequencer phases and transaction types
   Compiled ahead of the RTL; blocks reference entries as pet_bus_pkg::name */
package pet_bus_pkg;

    // Widths that carry meaning on the bus
    typedef logic [16:0] addr_t;        // Extended address, bit 16 = FPGA register space
    typedef logic [15:0] cpu_addr_t;    // What the 6502 drives
    typedef logic [7:0]  data_t;
    typedef logic [3:0]  phase_t;       // One of 16 phases per bus cycle

    // One SPI command as seen by the bus side
    typedef struct packed {
        logic  rw_n;                    // 1 = read
        addr_t addr;
        data_t data;                    // Write data, don't care on reads
    } spi_txn_t;

    // Decoded memory regions
    typedef struct packed {
        logic ram;
        logic pia1;
        logic pia2;
        logic via;
        logic io;                       // Whole I/O page
    } region_t;

    // SPI slot, FPGA owns the bus
    localparam phase_t PH_SPI_FIRST    = 4'd4;
    localparam phase_t PH_SPI_LAST     = 4'd7;

    // CPU clock high from here to end of cycle
    localparam phase_t PH_CPU_CLK_RISE = 4'd8;

    // CPU slot, chip selects live here
    localparam phase_t PH_CPU_FIRST    = 4'd12;
    localparam phase_t PH_CPU_LAST     = 4'd15;

    // Write strobe windows, two phases each
    localparam phase_t PH_STROBE_A     = 4'd6;
    localparam phase_t PH_STROBE_B     = 4'd14;

    // FPGA register space
    localparam addr_t CTRL_REG_ADDR    = 17'h1E800;    // CPU reset / ready
    localparam addr_t GFX_ADDR         = 17'h0E80F;    // Reads back the graphics jumper

    // PET memory map
    localparam cpu_addr_t RAM_TOP      = 16'h9000;     // RAM below here
    localparam cpu_addr_t IO_BASE      = 16'hE800;     // 256 byte I/O page
    localparam cpu_addr_t PIA1_BASE    = 16'hE810;
    localparam cpu_addr_t PIA2_BASE    = 16'hE820;
    localparam cpu_addr_t VIA_BASE     = 16'hE840;

    // SPI framing
    localparam int unsigned CMD_BYTES  = 4;            // rw/A16, A15:8, A7:0, data

endpackage

// File: verilog/pet_bus_top.sv
/* Bus-arbitration core of the PET board: SPI target, sequencer, decoder, control register
   Drives the shared bus during SPI slots and returns read data to the MCU */
`timescale 1ns/1ps

module pet_bus_top (
    input  logic                   clk16_i,
    input  logic                   rst_n_i,

    input  logic                   spi1_sck_i,
    input  logic                   spi1_cs_ni,
    input  logic                   spi1_rx_i,
    output logic                   spi1_tx_o,
    output logic                   spi_ready_o,

    input  pet_bus_pkg::cpu_addr_t bus_addr_i,
    output pet_bus_pkg::addr_t     bus_addr_o,
    output logic                   bus_addr_oe_o,
    input  pet_bus_pkg::data_t     bus_data_i,
    output pet_bus_pkg::data_t     bus_data_o,
    output logic                   bus_data_oe_o,
    input  logic                   bus_rw_ni,
    output logic                   bus_rw_no,
    output logic                   bus_rw_noe_o,

    output logic                   cpu_clk_o,
    output logic                   cpu_res_o,
    output logic                   cpu_ready_o,
    output logic                   cpu_be_o,

    output logic                   ram_oe_o,
    output logic                   ram_we_o,
    output logic [11:10]           ram_addr_o,

    output logic                   pia1_cs_o,
    output logic                   pia2_cs_o,
    output logic                   via_cs_o,
    output logic                   io_oe_o,

    input  logic                   gfx_i
);
    pet_bus_pkg::spi_txn_t txn;
    pet_bus_pkg::region_t  region;
    pet_bus_pkg::data_t    rd_data_q;       // Captured in the read slot
    logic txn_valid, txn_done;
    logic spi_en, cpu_en, strobe;
    logic spi_rd_en, spi_wr_en, cpu_rd_en, cpu_wr_en;

    spi_target u_spi (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .spi_sck_i   (spi1_sck_i),
        .spi_cs_ni   (spi1_cs_ni),
        .spi_rx_i    (spi1_rx_i),
        .spi_tx_o    (spi1_tx_o),
        .spi_ready_o (spi_ready_o),
        .txn_o       (txn),
        .txn_valid_o (txn_valid),
        .txn_done_i  (txn_done),
        .rd_data_i   (rd_data_q)
    );

    bus_sequencer u_seq (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .txn_valid_i (txn_valid),
        .txn_done_o  (txn_done),
        .spi_en_o    (spi_en),
        .cpu_en_o    (cpu_en),
        .strobe_o    (strobe),
        .cpu_clk_o   (cpu_clk_o),
        .cpu_be_o    (cpu_be_o)
    );

    // A16 only counts while the FPGA owns the bus, CPU cycles always see PET space
    address_decode u_dec (
        .addr_i   ({txn.addr[16] & spi_en, bus_addr_i}),
        .region_o (region)
    );

    assign spi_rd_en = spi_en &  txn.rw_n;
    assign spi_wr_en = spi_en & ~txn.rw_n;
    assign cpu_rd_en = cpu_en &  bus_rw_ni;
    assign cpu_wr_en = cpu_en & ~bus_rw_ni;

    control_reg u_ctrl (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .wr_en_i     (spi_wr_en & strobe),
        .addr_i      (txn.addr),
        .data_i      (txn.data),
        .cpu_res_o   (cpu_res_o),
        .cpu_ready_o (cpu_ready_o)
    );

    assign pia1_cs_o = region.pia1 & cpu_en;
    assign pia2_cs_o = region.pia2 & cpu_en;
    assign via_cs_o  = region.via  & cpu_en;
    assign io_oe_o   = region.io   & cpu_en;

    assign ram_oe_o   = region.ram & (spi_rd_en | cpu_rd_en);
    assign ram_we_o   = region.ram & (spi_wr_en | cpu_wr_en) & strobe;
    assign ram_addr_o = bus_addr_i[11:10];  // No VRAM mirroring

    // FPGA drives the bus only in its own slot
    assign bus_addr_oe_o = spi_en;
    assign bus_rw_noe_o  = spi_en;
    assign bus_data_oe_o = spi_wr_en;
    assign bus_addr_o    = txn.addr;
    assign bus_data_o    = txn.data;
    assign bus_rw_no     = txn.rw_n;

    // Loaded in the strobe window so it is settled when the target latches at phase 7
    always_ff @(posedge clk16_i) begin
        if (spi_rd_en && strobe) begin
            if (txn.addr == pet_bus_pkg::GFX_ADDR) rd_data_q <= {7'd0, gfx_i};
            else                                  rd_data_q <= bus_data_i;
        end
    end

    // RAM writes only land below RAM_TOP and never in FPGA register space
    a_we_ram: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        ram_we_o |-> bus_addr_i < pet_bus_pkg::RAM_TOP && !(spi_en && txn.addr[16]));

endmodule

// File: verilog/spi_target.sv
/* SPI mode 0 target: turns each 4-byte command into one bus transaction
   Holds txn_valid_o until the sequencer pulses done; MISO returns the last read */
`timescale 1ns/1ps

module spi_target (
    input  logic                  clk16_i,
    input  logic                  rst_n_i,
    input  logic                  spi_sck_i,
    input  logic                  spi_cs_ni,
    input  logic                  spi_rx_i,
    output logic                  spi_tx_o,
    output logic                  spi_ready_o,
    output pet_bus_pkg::spi_txn_t txn_o,
    output logic                  txn_valid_o,
    input  logic                  txn_done_i,
    input  pet_bus_pkg::data_t    rd_data_i
);
    logic [2:0] sck_sync;               // [2] is the previous sample for edges
    logic [2:0] cs_sync;
    logic [1:0] rx_sync;

    logic       sck_rise, sck_fall;
    logic       cs_fall, cs_rise, cs_active;
    logic       rx_s;

    logic [2:0] bit_cnt;
    logic [2:0] byte_cnt;               // Saturates at CMD_BYTES
    logic [6:0] rx_shift;
    pet_bus_pkg::data_t    rx_byte;
    pet_bus_pkg::data_t    tx_shift;
    pet_bus_pkg::data_t    rd_latch_q;  // Result of the last read
    pet_bus_pkg::spi_txn_t frame_q;     // Command being assembled
    pet_bus_pkg::spi_txn_t txn_q;
    logic       txn_valid_q;
    logic       frame_ok;

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            sck_sync <= 3'b000;         // Mode 0 idles low
            cs_sync  <= 3'b111;         // Deselected
            rx_sync  <= 2'b00;
        end else begin
            sck_sync <= {sck_sync[1:0], spi_sck_i};
            cs_sync  <= {cs_sync[1:0], spi_cs_ni};
            rx_sync  <= {rx_sync[0], spi_rx_i};
        end
    end

    assign sck_rise  =  sck_sync[1] & ~sck_sync[2];
    assign sck_fall  = ~sck_sync[1] &  sck_sync[2];
    assign cs_fall   = ~cs_sync[1]  &  cs_sync[2];
    assign cs_rise   =  cs_sync[1]  & ~cs_sync[2];
    assign cs_active = ~cs_sync[1];
    assign rx_s      =  rx_sync[1];
    assign rx_byte   = {rx_shift, rx_s};     // Completed byte on the 8th rising edge

    // Bit and byte position within the frame
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (cs_fall) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (cs_active && sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7 && byte_cnt != 3'(pet_bus_pkg::CMD_BYTES))
                byte_cnt <= byte_cnt + 3'd1;
        end
    end

    // MOSI sampled on rising SCK, bytes dropped into their fields
    always_ff @(posedge clk16_i) begin
        if (cs_active && sck_rise) begin
            rx_shift <= rx_byte[6:0];
            if (bit_cnt == 3'd7) begin
                case (byte_cnt)
                    3'd0: begin
                        frame_q.rw_n     <= rx_byte[7];
                        frame_q.addr[16] <= rx_byte[0];
                    end
                    3'd1:    frame_q.addr[15:8] <= rx_byte;
                    3'd2:    frame_q.addr[7:0]  <= rx_byte;
                    3'd3:    frame_q.data       <= rx_byte;
                    default: ;                  // Extra bytes ignored
                endcase
            end
        end
    end

    // MISO: read result during byte 0, zeros shifted in behind it
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i)                   tx_shift <= '0;
        else if (cs_fall)               tx_shift <= rd_latch_q;
        else if (cs_active && sck_fall) tx_shift <= {tx_shift[6:0], 1'b0};
    end
    assign spi_tx_o = tx_shift[7];

    // Complete frame, nothing pending
    assign frame_ok = cs_rise && byte_cnt == 3'(pet_bus_pkg::CMD_BYTES) && !txn_valid_q;

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i)        txn_valid_q <= 1'b0;
        else if (txn_done_i) txn_valid_q <= 1'b0;
        else if (frame_ok)   txn_valid_q <= 1'b1;
    end

    always_ff @(posedge clk16_i) begin
        if (frame_ok) txn_q <= frame_q;
    end

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i)                       rd_latch_q <= '0;
        else if (txn_done_i && txn_q.rw_n)  rd_latch_q <= rd_data_i;
    end

    assign txn_o       = txn_q;
    assign txn_valid_o = txn_valid_q;
    assign spi_ready_o = ~txn_valid_q;       // MCU may send the next command

    // Transaction held steady until the sequencer completes it
    a_txn_hold: assert property (@(posedge clk16_i) disable iff (!rst_n_i)
        txn_valid_o && !txn_done_i |=> txn_valid_o && $stable(txn_o));

endmodule
